//--- logic/enigma_pkg.sv
// ====================
// shared widths, table types and enums for the two-rotor enigma core
// imported by every rtl module of the cipher
// ====================
`default_nettype none

package enigma_pkg;

	// ====================
	// sizes
	// ====================
	localparam int CODE_W       = 6;   // bits per code word
	localparam int ROTOR_DEPTH  = 64;  // entries per rotor table
	localparam int GROUP_W      = 3;   // slot index inside a group
	localparam int GROUP_SIZE   = 8;   // entries per rotor b group
	localparam int SHIFT_STEP_W = 2;   // low bits added to the rotor a shift
	localparam int REFLECT_MASK = 63;  // reflector is a plain xor

	// ====================
	// types
	// ====================
	typedef logic [CODE_W-1:0] code_word_t;

	// entry i of a rotor sits at index i
	typedef code_word_t [ROTOR_DEPTH-1:0] rotor_table_t;

	// flag i tells which slot of a group entry i maps to
	typedef logic [GROUP_SIZE-1:0][GROUP_W-1:0] mode_flags_t;

	typedef enum logic {
		CRYPT_ENCRYPT = 1'b0,
		CRYPT_DECRYPT = 1'b1
	} crypt_mode_e;

	typedef enum logic {
		LOAD_ROTOR_A = 1'b0,
		LOAD_ROTOR_B = 1'b1
	} load_phase_e;

	typedef struct packed {
		logic       valid;
		code_word_t word;
	} code_beat_t;

	// flag shuffles, one row per selector value
	// new flag i takes old flag MODE_PERMS[sel][i]
	localparam logic [GROUP_W-1:0] MODE_PERMS [GROUP_SIZE][GROUP_SIZE] = '{
		'{0, 1, 2, 3, 4, 5, 6, 7},  // identity, also the idle order
		'{1, 0, 3, 2, 5, 4, 7, 6},
		'{2, 3, 0, 1, 6, 7, 4, 5},
		'{0, 4, 5, 6, 1, 2, 3, 7},
		'{4, 5, 6, 7, 0, 1, 2, 3},
		'{5, 6, 7, 3, 4, 0, 1, 2},
		'{6, 7, 3, 2, 5, 4, 0, 1},
		'{7, 6, 5, 4, 3, 2, 1, 0}   // full reverse
	};

endpackage : enigma_pkg

`default_nettype wire

//--- logic/rotor_table_loader.sv
// ====================
// fills rotor a then rotor b from the level-valid load stream
// and latches the crypt mode given with the first rotor a word
// ====================
`timescale 1ns/1ps
`default_nettype none

module rotor_table_loader (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic                      crypt_mode,
	input  enigma_pkg::code_word_t    code_in,
	output enigma_pkg::rotor_table_t  rotor_a,
	output enigma_pkg::rotor_table_t  rotor_b,
	output enigma_pkg::crypt_mode_e   mode
);

	import enigma_pkg::*;

	logic [CODE_W-1:0] cnt;    // entry index inside the current table
	load_phase_e       phase;

	// ====================
	// counter and phase
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			phase <= LOAD_ROTOR_A;
			mode  <= CRYPT_ENCRYPT;
		end else if (in_valid) begin
			cnt <= cnt + 1'b1;  // wraps 63 -> 0
			if (cnt == CODE_W'(ROTOR_DEPTH - 1))
				phase <= (phase == LOAD_ROTOR_A) ? LOAD_ROTOR_B : LOAD_ROTOR_A;
			if (phase == LOAD_ROTOR_A && cnt == '0)
				mode <= crypt_mode_e'(crypt_mode);  // only valid on the first word
		end
	end

	// ====================
	// table write
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rotor_a <= '0;
			rotor_b <= '0;
		end else if (in_valid) begin
			if (phase == LOAD_ROTOR_A)
				rotor_a[cnt] <= code_in;
			else
				rotor_b[cnt] <= code_in;
		end
	end

endmodule : rotor_table_loader

`default_nettype wire

//--- logic/rotor_a_stage.sv
// ====================
// rotor a forward lookup with shift, inverse search and unshift
// owns the shift accumulator, cleared in every idle cycle
// ====================
`timescale 1ns/1ps
`default_nettype none

module rotor_a_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  enigma_pkg::code_beat_t    beat,
	input  enigma_pkg::crypt_mode_e   mode,
	input  enigma_pkg::rotor_table_t  rotor_a,
	output enigma_pkg::code_word_t    fwd_a,
	input  enigma_pkg::code_word_t    inv_b,
	output enigma_pkg::code_word_t    result
);

	import enigma_pkg::*;

	code_word_t              shift;      // accumulated rotation
	code_word_t              fwd_idx;
	code_word_t              inv_idx;    // where inv_b sits in rotor a
	logic                    inv_hit;
	logic [SHIFT_STEP_W-1:0] step;

	// ====================
	// forward path
	// ====================
	// 6-bit subtract wraps, so this is already mod 64
	assign fwd_idx = beat.word - shift;
	assign fwd_a   = rotor_a[fwd_idx];

	// ====================
	// inverse path
	// ====================
	always_comb begin
		inv_idx = '0;  // tables are permutations, default never used
		inv_hit = 1'b0;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			if (rotor_a[i] == inv_b) begin
				inv_idx = CODE_W'(i);
				inv_hit = 1'b1;
			end
		end
	end

	assign result = inv_idx + shift;  // undo the rotation

	// ====================
	// shift accumulator
	// ====================
	// decrypt steps on the inverse rotor b word so that both
	// directions advance by the same amount
	assign step = (mode == CRYPT_DECRYPT) ? inv_b[SHIFT_STEP_W-1:0]
	                                      : fwd_a[SHIFT_STEP_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shift <= '0;
		else if (beat.valid)
			shift <= shift + CODE_W'(step);
		else
			shift <= '0;  // every message starts unrotated
	end

	// rotor b hands back a word that rotor a must hold
	a_inv_hit : assert property (@(posedge clk) disable iff (!rst_n)
		beat.valid |-> inv_hit);

endmodule : rotor_a_stage

`default_nettype wire

//--- logic/rotor_b_reflect_stage.sv
// ====================
// rotor b forward lookup through the mode flags, reflector and
// inverse rotor b search; owns the flags and reshuffles them per word
// ====================
`timescale 1ns/1ps
`default_nettype none

module rotor_b_reflect_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      beat_valid,
	input  enigma_pkg::crypt_mode_e   mode,
	input  enigma_pkg::rotor_table_t  rotor_b,
	input  enigma_pkg::code_word_t    fwd_a,
	output enigma_pkg::code_word_t    inv_b
);

	import enigma_pkg::*;

	mode_flags_t        flags;       // current slot order
	mode_flags_t        flags_next;
	logic [GROUP_W-1:0] fwd_slot;
	code_word_t         fwd_idx;
	code_word_t         fwd_b;       // forward rotor b output
	code_word_t         refl;        // reflector output
	code_word_t         inv_idx;     // where refl sits in rotor b
	logic               inv_hit;
	logic [GROUP_W-1:0] inv_slot;
	logic [GROUP_W-1:0] perm_sel;

	// ====================
	// forward rotor b and reflector
	// ====================
	assign fwd_slot = flags[fwd_a[GROUP_W-1:0]];
	assign fwd_idx  = {fwd_a[CODE_W-1:GROUP_W], fwd_slot};  // group base + slot
	assign fwd_b    = rotor_b[fwd_idx];
	assign refl     = fwd_b ^ CODE_W'(REFLECT_MASK);

	// ====================
	// inverse rotor b
	// ====================
	always_comb begin
		inv_idx = '0;
		inv_hit = 1'b0;
		for (int i = 0; i < ROTOR_DEPTH; i++) begin
			if (rotor_b[i] == refl) begin
				inv_idx = CODE_W'(i);
				inv_hit = 1'b1;
			end
		end
	end

	// which flag points at the matched slot
	always_comb begin
		inv_slot = '0;
		for (int i = 0; i < GROUP_SIZE; i++) begin
			if (flags[i] == inv_idx[GROUP_W-1:0])
				inv_slot = GROUP_W'(i);
		end
	end

	assign inv_b = {inv_idx[CODE_W-1:GROUP_W], inv_slot};

	// ====================
	// flag update
	// ====================
	assign perm_sel = (mode == CRYPT_DECRYPT) ? refl[GROUP_W-1:0] : fwd_b[GROUP_W-1:0];

	always_comb begin
		for (int i = 0; i < GROUP_SIZE; i++) begin
			if (beat_valid)
				flags_next[i] = flags[MODE_PERMS[perm_sel][i]];
			else
				flags_next[i] = MODE_PERMS[0][i];  // back to identity when idle
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < GROUP_SIZE; i++)
				flags[i] <= MODE_PERMS[0][i];
		end else begin
			flags <= flags_next;
		end
	end

	// one-hot sum covers all eight values only for a true permutation
	function automatic logic flags_are_perm(input mode_flags_t f);
		logic [GROUP_SIZE-1:0] seen;
		seen = '0;
		for (int i = 0; i < GROUP_SIZE; i++)
			seen[f[i]] = 1'b1;
		return &seen;
	endfunction

	b_inv_hit : assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> inv_hit);

	// shuffles compose, so the order must stay a permutation across words
	b_flags_perm : assert property (@(posedge clk) disable iff (!rst_n)
		flags_are_perm(flags));

endmodule : rotor_b_reflect_stage

`default_nettype wire

//--- logic/enigma_top.sv
// ====================
// enigma core top: input beat register, loader, both rotor stages
// and the output register; one word in, one word out, two edges later
// ====================
`timescale 1ns/1ps
`default_nettype none

module enigma_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,    // rotor table words
	input  logic                    in_valid_2,  // code words
	input  logic                    crypt_mode,
	input  enigma_pkg::code_word_t  code_in,
	output logic                    out_valid,
	output enigma_pkg::code_word_t  out_code
);

	import enigma_pkg::*;

	code_beat_t   beat;
	rotor_table_t rotor_a;
	rotor_table_t rotor_b;
	crypt_mode_e  mode;
	code_word_t   fwd_a;
	code_word_t   inv_b;
	code_word_t   result;

	// ====================
	// input and output registers
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat      <= '0;
			out_valid <= 1'b0;
			out_code  <= '0;
		end else begin
			beat.valid <= in_valid_2;
			beat.word  <= code_in;
			out_valid  <= beat.valid;
			out_code   <= beat.valid ? result : '0;  // quiet bus when idle
		end
	end

	rotor_table_loader u_loader (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.rotor_a    (rotor_a),
		.rotor_b    (rotor_b),
		.mode       (mode)
	);

	rotor_a_stage u_rotor_a (
		.clk     (clk),
		.rst_n   (rst_n),
		.beat    (beat),
		.mode    (mode),
		.rotor_a (rotor_a),
		.fwd_a   (fwd_a),
		.inv_b   (inv_b),
		.result  (result)
	);

	rotor_b_reflect_stage u_rotor_b (
		.clk        (clk),
		.rst_n      (rst_n),
		.beat_valid (beat.valid),
		.mode       (mode),
		.rotor_b    (rotor_b),
		.fwd_a      (fwd_a),
		.inv_b      (inv_b)
	);

	// load and stream phases never overlap
	top_no_overlap : assert property (@(posedge clk) disable iff (!rst_n)
		!(in_valid && in_valid_2));

endmodule : enigma_top

`default_nettype wire

//--- bench/enigma_model.svh
// ====================
// reference enigma model for the testbench: lcg, table shuffle, cipher
// included inside the testbench module after the package import
// ====================
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

int unsigned  lcg_state = 53;
rotor_table_t tab_a;            // rotor a as loaded
rotor_table_t tab_b;
code_word_t   m_shift;          // model shift
logic [2:0]   m_flags [8];      // model slot order

function automatic int unsigned lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state >> 8;  // low bits cycle too fast
endfunction

// fisher-yates over the identity
function automatic rotor_table_t random_table();
	rotor_table_t t;
	code_word_t   tmp;
	int           j;
	for (int i = 0; i < 64; i++)
		t[i] = code_word_t'(i);
	for (int i = 63; i > 0; i--) begin
		j = lcg_next() % (i + 1);
		tmp = t[i];
		t[i] = t[j];
		t[j] = tmp;
	end
	return t;
endfunction

function automatic code_word_t find_index(input rotor_table_t t, input code_word_t v);
	code_word_t idx;
	idx = '0;
	for (int i = 0; i < 64; i++)
		if (t[i] == v)
			idx = code_word_t'(i);
	return idx;
endfunction

function automatic void model_reset();
	m_shift = '0;
	for (int i = 0; i < 8; i++)
		m_flags[i] = 3'(i);
endfunction

function automatic code_word_t model_word(input code_word_t c, input logic dec);
	code_word_t a;
	code_word_t b;
	code_word_t r;
	code_word_t j;
	code_word_t k;
	code_word_t res;
	logic [2:0] sel;
	logic [2:0] old_f [8];
	a = tab_a[code_word_t'(c - m_shift)];
	b = tab_b[{a[5:3], m_flags[a[2:0]]}];
	r = b ^ 6'd63;                      // reflector
	j = find_index(tab_b, r);
	k = {j[5:3], 3'd0};
	for (int i = 0; i < 8; i++)
		if (m_flags[i] == j[2:0])
			k[2:0] = 3'(i);
	res = find_index(tab_a, k) + m_shift;
	m_shift = m_shift + (dec ? k[1:0] : a[1:0]);
	sel = dec ? r[2:0] : b[2:0];
	old_f = m_flags;
	for (int i = 0; i < 8; i++)
		m_flags[i] = old_f[MODE_PERMS[sel][i]];
	return res;
endfunction

`endif

//--- bench/enigma_tb.sv
// ====================
// testbench for the enigma core: random tables and messages,
// checked word by word against the model in the header
// ====================
`timescale 1ns/1ps
`default_nettype none

module enigma_tb;

	import enigma_pkg::*;

	`include "enigma_model.svh"

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic       in_valid_2;
	logic       crypt_mode;
	code_word_t code_in;
	logic       out_valid;
	code_word_t out_code;

	int         cycle = 0;   // rising edges seen
	int         errors = 0;
	int         errs_before = 0;
	int         tests_ok = 0;
	int         tests_bad = 0;
	code_word_t msg_q[$];
	code_word_t exp_q[$];
	code_word_t got_q[$];
	code_word_t plain_q[$];
	code_word_t saved_q[$];
	int         got_cyc[$];
	int         sent_cyc[$];

	enigma_top dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_valid_2 (in_valid_2),
		.crypt_mode (crypt_mode),
		.code_in    (code_in),
		.out_valid  (out_valid),
		.out_code   (out_code)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// monitor
	// ====================
	always @(posedge clk) begin
		if (out_valid) begin
			got_q.push_back(out_code);
			got_cyc.push_back(cycle);
		end else begin
			check_value(out_code, 0, "out_code while out_valid low");
		end
		cycle <= cycle + 1;
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic load_tables(input logic dec);
		for (int i = 0; i < 128; i++) begin
			@(posedge clk);
			#1;
			in_valid   = 1'b1;
			crypt_mode = (i == 0) ? dec : ~dec;  // only the first word carries the mode
			if (i < 64)
				code_in = tab_a[i];
			else
				code_in = tab_b[i - 64];
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		code_in  = '0;
	endtask

	task automatic random_message(input int n);
		msg_q.delete();
		repeat (n) msg_q.push_back(code_word_t'(lcg_next() >> 4));
	endtask

	// back to back words, then the model result for each one
	task automatic run_message(input logic dec);
		int waited;
		got_q.delete();
		got_cyc.delete();
		sent_cyc.delete();
		exp_q.delete();
		model_reset();
		foreach (msg_q[i])
			exp_q.push_back(model_word(msg_q[i], dec));
		foreach (msg_q[i]) begin
			@(posedge clk);
			#1;
			in_valid_2 = 1'b1;
			code_in    = msg_q[i];
			sent_cyc.push_back(cycle);
		end
		@(posedge clk);
		#1;
		in_valid_2 = 1'b0;
		code_in    = '0;
		waited = 0;
		while (got_q.size() < msg_q.size() && waited < 200) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < msg_q.size()) begin
			$display("timeout: only %0d of %0d output words arrived", got_q.size(), msg_q.size());
			$display("test failed");
			$finish;
		end else begin
			for (int i = 0; i < 4; i++)
				@(posedge clk);  // room for stray pulses
			check_value(got_q.size(), msg_q.size(), "out_valid pulse count");
			foreach (exp_q[i]) begin
				check_value(got_q[i], exp_q[i], "out_code vs model");
				check_value(got_cyc[i] - sent_cyc[i], 2, "edges from input to out_valid");
			end
		end
	endtask

	task automatic close_test(input string name);
		if (errors == errs_before) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d mismatches", name, errors - errs_before);
		end
		errs_before = errors;
	endtask

	// ====================
	// tests
	// ====================
	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_valid_2 = 1'b0;
		crypt_mode = 1'b0;
		code_in    = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		tab_a = random_table();
		tab_b = random_table();
		load_tables(1'b0);
		check_value(got_q.size(), 0, "out_valid high before first code word");
		random_message(20);
		run_message(1'b0);
		close_test("latency and pulse count");

		load_tables(1'b0);
		random_message(40);
		plain_q = msg_q;
		run_message(1'b0);
		saved_q = got_q;  // ciphertext
		close_test("encrypt");

		load_tables(1'b1);
		msg_q = saved_q;
		run_message(1'b1);
		foreach (plain_q[i])
			check_value(got_q[i], plain_q[i], "decrypt vs plaintext");
		close_test("decrypt");

		load_tables(1'b0);
		random_message(10);
		run_message(1'b0);
		saved_q = got_q;
		for (int i = 0; i < 6; i++)
			@(posedge clk);  // idle gap
		run_message(1'b0);
		foreach (saved_q[i])
			check_value(got_q[i], saved_q[i], "repeated message");
		close_test("state reset");

		tab_a = random_table();
		tab_b = random_table();
		load_tables(1'b0);
		random_message(30);
		run_message(1'b0);
		close_test("table reload");

		$display("summary: %0d ok, %0d bad, %0d mismatches", tests_ok, tests_bad, errors);
		if (tests_bad == 0 && errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule : enigma_tb

`default_nettype wire

//--- src.f
+incdir+bench
logic/enigma_pkg.sv
logic/rotor_table_loader.sv
logic/rotor_a_stage.sv
logic/rotor_b_reflect_stage.sv
logic/enigma_top.sv
bench/enigma_tb.sv
